/* dcache.f */
+incdir+include
design/dcache_pkg.sv
design/dcache_sram.sv
design/dcache_way.sv
design/dcache_replace.sv
design/dcache_axi_master.sv
design/dcache_ctrl.sv
design/dcache.sv
test/axi_mem_model.sv
test/dcache_tb.sv

/* design/dcache.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       req,
    input  wire dcache_pkg::cpu_req_t cpu,
    output logic                      addr_ok,
    output logic                      data_ok,
    output dcache_pkg::word_t         rdata,
    output dcache_pkg::axi_ar_t       ar,
    output logic                      arvalid,
    input  wire                       arready,
    input  wire dcache_pkg::axi_r_t   r,
    input  wire                       rvalid,
    output logic                      rready,
    output dcache_pkg::axi_aw_t       aw,
    output logic                      awvalid,
    input  wire                       awready,
    output dcache_pkg::axi_w_t        w,
    output logic                      wvalid,
    input  wire                       wready,
    input  wire                       bvalid,
    output logic                      bready
);

    import dcache_pkg::*;

    logic [`DCACHE_IDX_W-1:0]                   way_idx;
    logic [`DCACHE_TAG_W-1:0]                   lookup_tag;
    logic [`DCACHE_WAYS-1:0]                    way_fill;
    logic [`DCACHE_WAYS-1:0]                    way_wen;
    logic [`DCACHE_OFS_W-1:0]                   bank;
    word_t                                      way_wdata;
    logic [`DCACHE_WAYS-1:0]                    way_hit;
    line_t [`DCACHE_WAYS-1:0]                   way_line;
    logic [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0] way_tag;
    logic [`DCACHE_IDX_W-1:0]                   rep_idx;
    logic                                       rep_hit;
    logic                                       rep_hit_way;
    logic                                       rep_fill;
    logic                                       rep_write;
    logic                                       victim_way;
    logic                                       victim_dirty;
    logic                                       rd_start;
    logic                                       wr_start;
    axi_ar_t                                    rd_req;
    axi_aw_t                                    wr_req;
    line_t                                      wr_line;
    logic [3:0]                                 wr_sel;
    logic                                       rd_beat;
    axi_r_t                                     rd_data;
    logic                                       wr_done;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .cpu          (cpu),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .way_idx      (way_idx),
        .lookup_tag   (lookup_tag),
        .way_fill     (way_fill),
        .way_wen      (way_wen),
        .bank         (bank),
        .way_wdata    (way_wdata),
        .way_hit      (way_hit),
        .way_line     (way_line),
        .way_tag      (way_tag),
        .rep_idx      (rep_idx),
        .rep_hit      (rep_hit),
        .rep_hit_way  (rep_hit_way),
        .rep_fill     (rep_fill),
        .rep_write    (rep_write),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .rd_start     (rd_start),
        .rd_req       (rd_req),
        .wr_start     (wr_start),
        .wr_req       (wr_req),
        .wr_line      (wr_line),
        .wr_sel       (wr_sel),
        .rd_beat      (rd_beat),
        .rd_data      (rd_data),
        .wr_done      (wr_done)
    );

    for (genvar g = 0; g < `DCACHE_WAYS; g++) begin : g_way
        dcache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .idx        (way_idx),
            .lookup_tag (lookup_tag),
            .fill       (way_fill[g]),
            .wen        (way_wen[g]),
            .bank       (bank),
            .wdata      (way_wdata),
            .hit        (way_hit[g]),
            .tag        (way_tag[g]),
            .line       (way_line[g])
        );
    end

    dcache_replace u_replace (
        .clk          (clk),
        .rst          (rst),
        .idx          (rep_idx),
        .lookup_hit   (rep_hit),
        .hit_way      (rep_hit_way),
        .fill         (rep_fill),
        .is_write     (rep_write),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    dcache_axi_master u_axi (
        .clk      (clk),
        .rst      (rst),
        .rd_start (rd_start),
        .rd_req   (rd_req),
        .wr_start (wr_start),
        .wr_req   (wr_req),
        .wr_line  (wr_line),
        .wr_sel   (wr_sel),
        .rd_beat  (rd_beat),
        .rd_data  (rd_data),
        .wr_done  (wr_done),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid)
    );

    assign rready = 1'b1;
    assign bready = 1'b1;

endmodule

`default_nettype wire

/* design/dcache_axi_master.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_axi_master (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       rd_start,
    input  wire dcache_pkg::axi_ar_t  rd_req,
    input  wire                       wr_start,
    input  wire dcache_pkg::axi_aw_t  wr_req,
    input  wire dcache_pkg::line_t    wr_line,
    input  wire [3:0]                 wr_sel,
    output logic                      rd_beat,
    output dcache_pkg::axi_r_t        rd_data,
    output logic                      wr_done,
    output dcache_pkg::axi_ar_t       ar,
    output logic                      arvalid,
    input  wire                       arready,
    input  wire dcache_pkg::axi_r_t   r,
    input  wire                       rvalid,
    output dcache_pkg::axi_aw_t       aw,
    output logic                      awvalid,
    input  wire                       awready,
    output dcache_pkg::axi_w_t        w,
    output logic                      wvalid,
    input  wire                       wready,
    input  wire                       bvalid
);

    import dcache_pkg::*;

    logic [`DCACHE_OFS_W-1:0] wcnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wcnt    <= '0;
        end else begin
            if (rd_start) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            if (wr_start) begin
                awvalid <= 1'b1;
            end else if (awready) begin
                awvalid <= 1'b0;
            end
            // data phase opens once AW is taken
            if (awvalid && awready) begin
                wvalid <= 1'b1;
                wcnt   <= '0;
            end else if (wvalid && wready) begin
                if (w.last) begin
                    wvalid <= 1'b0;
                end
                wcnt <= wcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            ar <= rd_req;
        end
        if (wr_start) begin
            aw <= wr_req;
        end
    end

    always_comb begin
        w.data = wr_line[wcnt];
        w.strb = wr_sel;
        w.last = 4'(wcnt) == aw.len;
    end

    // rready and bready are tied high at the top
    assign rd_beat = rvalid;
    assign rd_data = r;
    assign wr_done = bvalid;

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_ctrl (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        req,
    input  wire dcache_pkg::cpu_req_t                  cpu,
    output logic                                       addr_ok,
    output logic                                       data_ok,
    output dcache_pkg::word_t                          rdata,
    output logic [`DCACHE_IDX_W-1:0]                   way_idx,
    output logic [`DCACHE_TAG_W-1:0]                   lookup_tag,
    output logic [`DCACHE_WAYS-1:0]                    way_fill,
    output logic [`DCACHE_WAYS-1:0]                    way_wen,
    output logic [`DCACHE_OFS_W-1:0]                   bank,
    output dcache_pkg::word_t                          way_wdata,
    input  wire [`DCACHE_WAYS-1:0]                     way_hit,
    input  wire dcache_pkg::line_t [`DCACHE_WAYS-1:0]  way_line,
    input  wire [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0]  way_tag,
    output logic [`DCACHE_IDX_W-1:0]                   rep_idx,
    output logic                                       rep_hit,
    output logic                                       rep_hit_way,
    output logic                                       rep_fill,
    output logic                                       rep_write,
    input  wire                                        victim_way,
    input  wire                                        victim_dirty,
    output logic                                       rd_start,
    output dcache_pkg::axi_ar_t                        rd_req,
    output logic                                       wr_start,
    output dcache_pkg::axi_aw_t                        wr_req,
    output dcache_pkg::line_t                          wr_line,
    output logic [3:0]                                 wr_sel,
    input  wire                                        rd_beat,
    input  wire dcache_pkg::axi_r_t                    rd_data,
    input  wire                                        wr_done
);

    import dcache_pkg::*;

    localparam int idx_lo = `DCACHE_OFS_W + 2;

    ctrl_state_t              state;
    ctrl_state_t              state_next;
    cpu_req_t                 req_map;
    cpu_req_t                 req_q;
    logic                     unc_in;
    logic                     unc_q;
    logic                     started;
    logic                     done_q;
    word_t                    rdata_q;
    line_t                    wb_line;
    logic [`DCACHE_TAG_W-1:0] wb_tag;
    logic [`DCACHE_OFS_W-1:0] beat_cnt;
    logic [`DCACHE_OFS_W-1:0] ofs_q;
    logic                     hit_any;
    word_t                    hit_word;
    paddr_t                   word_addr;

    function automatic word_t merge_word(input word_t old_w, input word_t new_w,
                                         input logic [3:0] sel);
        word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // kseg0/kseg1 drop to physical, kseg1 bypasses the cache
    always_comb begin
        req_map = cpu;
        unc_in  = cpu.addr[31:29] == `DCACHE_SEG_UNCACHED;
        if (unc_in || cpu.addr[31:29] == `DCACHE_SEG_DIRECT) begin
            req_map.addr = {3'b000, cpu.addr[28:0]};
        end
    end

    assign rep_idx    = req_q.addr[idx_lo +: `DCACHE_IDX_W];
    assign ofs_q      = req_q.addr[2 +: `DCACHE_OFS_W];
    assign lookup_tag = req_q.addr[31 -: `DCACHE_TAG_W];
    assign word_addr  = {req_q.addr[31:2], 2'b00};
    assign hit_any    = |way_hit;
    assign hit_word   = way_line[way_hit[1]][ofs_q];

    // write hits block the port for a cycle, the RAMs have one port
    assign addr_ok = req && (state == s_idle || (state == s_lookup && hit_any && !req_q.wr));
    assign data_ok = done_q || (state == s_lookup && hit_any);
    assign rdata   = done_q ? rdata_q : hit_word;
    assign way_idx = addr_ok ? req_map.addr[idx_lo +: `DCACHE_IDX_W] : rep_idx;

    always_comb begin
        state_next = state;
        case (state)
            s_idle, s_lookup: begin
                if (state == s_lookup && !hit_any) begin
                    state_next = victim_dirty ? s_writeback : s_fetch;
                end else if (addr_ok && !unc_in) begin
                    state_next = s_lookup;
                end else if (addr_ok) begin
                    state_next = cpu.wr ? s_unc_write : s_unc_read;
                end else begin
                    state_next = s_idle;
                end
            end
            s_writeback: begin
                if (wr_done) begin
                    state_next = s_fetch;
                end
            end
            s_fetch: begin
                if (rd_beat && rd_data.last) begin
                    state_next = s_update;
                end
            end
            s_unc_read: begin
                if (rd_beat) begin
                    state_next = s_idle;
                end
            end
            s_unc_write: begin
                if (wr_done) begin
                    state_next = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= s_idle;
            started  <= 1'b0;
            done_q   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            state  <= state_next;
            done_q <= state == s_update || (state == s_unc_read && rd_beat)
                      || (state == s_unc_write && wr_done);
            if (state_next != state) begin
                started <= 1'b0;
            end else if (rd_start || wr_start) begin
                started <= 1'b1;
            end
            if (|way_fill) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_q <= req_map;
            unc_q <= unc_in;
        end
        // keep the victim while its RAM slot is refilled
        if (state == s_lookup && !hit_any) begin
            wb_line <= way_line[victim_way];
            wb_tag  <= way_tag[victim_way];
        end
        if (rd_beat && (state == s_unc_read || (state == s_fetch && beat_cnt == ofs_q))) begin
            rdata_q <= rd_data.data;
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_fill[w] = state == s_fetch && rd_beat && victim_way == w[0];
            way_wen[w]  = req_q.wr && ((state == s_lookup && way_hit[w])
                          || (state == s_update && victim_way == w[0]));
        end
    end

    assign bank      = state == s_fetch ? beat_cnt : ofs_q;
    assign way_wdata = state == s_fetch ? rd_data.data :
                       merge_word(state == s_update ? rdata_q : hit_word, req_q.wdata, req_q.sel);

    assign rep_hit     = state == s_lookup && hit_any;
    assign rep_hit_way = way_hit[1];
    assign rep_fill    = state == s_update;
    assign rep_write   = req_q.wr;

    assign rd_start    = (state == s_fetch || state == s_unc_read) && !started;
    assign wr_start    = (state == s_writeback || state == s_unc_write) && !started;
    assign rd_req.addr = unc_q ? word_addr : {req_q.addr[31:idx_lo], {idx_lo{1'b0}}};
    assign rd_req.len  = unc_q ? 4'd0 : 4'(`DCACHE_WORDS - 1);
    assign wr_req.addr = unc_q ? word_addr : {wb_tag, rep_idx, {idx_lo{1'b0}}};
    assign wr_req.len  = rd_req.len;
    assign wr_sel      = unc_q ? req_q.sel : 4'hf;

    // single uncached store goes out as word 0
    always_comb begin
        wr_line = wb_line;
        if (unc_q) begin
            wr_line    = '0;
            wr_line[0] = req_q.wdata;
        end
    end

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] paddr_t;

    typedef struct packed {
        logic                     valid;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic       wr;
        logic [3:0] sel;
        paddr_t     addr;
        word_t      wdata;
    } cpu_req_t;

    typedef struct packed {
        paddr_t     addr;
        logic [3:0] len;
    } axi_ar_t;

    typedef struct packed {
        paddr_t     addr;
        logic [3:0] len;
    } axi_aw_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_r_t;

    typedef word_t [`DCACHE_WORDS-1:0] line_t;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_writeback,
        s_fetch,
        s_update,
        s_unc_read,
        s_unc_write
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/dcache_replace.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_replace (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`DCACHE_IDX_W-1:0]  idx,
    input  wire                      lookup_hit,
    input  wire                      hit_way,
    input  wire                      fill,
    input  wire                      is_write,
    output logic                     victim_way,
    output logic                     victim_dirty
);

    // lru[set] names the way to evict next
    logic [`DCACHE_SETS-1:0] lru;
    logic [`DCACHE_SETS-1:0] dirty [`DCACHE_WAYS];

    assign victim_way   = lru[idx];
    assign victim_dirty = dirty[victim_way][idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru   <= '0;
            dirty <= '{default: '0};
        end else if (lookup_hit) begin
            lru[idx] <= ~hit_way;
            if (is_write) begin
                dirty[hit_way][idx] <= 1'b1;
            end
        end else if (fill) begin
            // refilled way becomes most recent
            lru[idx]               <= ~lru[idx];
            dirty[victim_way][idx] <= is_write;
        end
    end

endmodule

`default_nettype wire

/* design/dcache_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_sram #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 128
) (
    input  wire                       clk,
    input  wire                       we,
    input  wire [$clog2(depth)-1:0]   addr,
    input  wire entry_t               wdata,
    output entry_t                    rdata
);

    entry_t mem [depth];

    // registered read, new data shows through on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* design/dcache_way.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_way (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [`DCACHE_IDX_W-1:0]      idx,
    input  wire [`DCACHE_TAG_W-1:0]      lookup_tag,
    input  wire                          fill,
    input  wire                          wen,
    input  wire [`DCACHE_OFS_W-1:0]      bank,
    input  wire dcache_pkg::word_t       wdata,
    output logic                         hit,
    output logic [`DCACHE_TAG_W-1:0]     tag,
    output dcache_pkg::line_t            line
);

    import dcache_pkg::*;

    logic [`DCACHE_SETS-1:0]  valid;
    logic [`DCACHE_IDX_W-1:0] idx_q;
    tag_entry_t               tag_wr;
    tag_entry_t               tag_rd;

    assign tag_wr = '{valid: 1'b1, tag: lookup_tag};

    dcache_sram #(.entry_t(tag_entry_t), .depth(`DCACHE_SETS)) u_tag (
        .clk   (clk),
        .we    (fill),
        .addr  (idx),
        .wdata (tag_wr),
        .rdata (tag_rd)
    );

    // one RAM per word; a fill beat or a merged write hits a single bank
    for (genvar b = 0; b < `DCACHE_WORDS; b++) begin : g_bank
        dcache_sram #(.entry_t(word_t), .depth(`DCACHE_SETS)) u_bank (
            .clk   (clk),
            .we    ((fill || wen) && bank == `DCACHE_OFS_W'(b)),
            .addr  (idx),
            .wdata (wdata),
            .rdata (line[b])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill) begin
            valid[idx] <= 1'b1;
        end
    end

    // follows the RAM read latency
    always_ff @(posedge clk) begin
        idx_q <= idx;
    end

    assign tag = tag_rd.tag;
    assign hit = valid[idx_q] && tag_rd.tag == lookup_tag;

endmodule

`default_nettype wire

/* include/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// geometry: 128 sets x 2 ways x 32-byte lines
`define DCACHE_SETS 128
`define DCACHE_WAYS 2
// words per line, also the AXI burst length
`define DCACHE_WORDS 8

// address split
`define DCACHE_TAG_W 20
`define DCACHE_IDX_W 7
`define DCACHE_OFS_W 3

// kseg codes in addr[31:29]
`define DCACHE_SEG_UNCACHED 3'b101
`define DCACHE_SEG_DIRECT 3'b100

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module dcache_tb -f dcache.f -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
exit 0

/* test/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter int          words = 5120,
    parameter logic [31:0] seed  = 32'h1
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      stall,
    input  wire dcache_pkg::axi_ar_t ar,
    input  wire                      arvalid,
    output logic                     arready,
    output dcache_pkg::axi_r_t       r,
    output logic                     rvalid,
    input  wire                      rready,
    input  wire dcache_pkg::axi_aw_t aw,
    input  wire                      awvalid,
    output logic                     awready,
    input  wire dcache_pkg::axi_w_t  w,
    input  wire                      wvalid,
    output logic                     wready,
    output logic                     bvalid,
    input  wire                      bready,
    output int                       aw_count,
    output logic [3:0]               aw_len
);

    import dcache_pkg::*;

    localparam int ptr_w = $clog2(words);

    word_t             mem [words];
    logic [31:0]       rnd;
    int                sd = seed;
    logic [ptr_w-1:0]  rd_ptr;
    logic [3:0]        rd_left;
    logic              rd_busy;
    logic [ptr_w-1:0]  wr_ptr;
    logic              wr_busy;
    logic              b_due;

    // one random draw per cycle, split across the channels
    always @(posedge clk) begin
        rnd <= $random(sd);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            b_due    <= 1'b0;
            aw_count <= 0;
            aw_len   <= '0;
            for (int i = 0; i < words; i++) begin
                mem[i] <= 32'(i) * 32'h9e3779b9 ^ 32'h5bd1e995;
            end
        end else begin
            arready <= !rd_busy && (!stall || rnd[1:0] != 2'b00);
            awready <= !wr_busy && (!stall || rnd[3:2] != 2'b00);
            wready  <= !stall || rnd[5:4] != 2'b00;

            // read burst, one beat per granted cycle
            if (!rvalid || rready) begin
                rvalid <= 1'b0;
                if (rd_busy && (!stall || rnd[7:6] != 2'b00)) begin
                    rvalid  <= 1'b1;
                    r.data  <= mem[rd_ptr];
                    r.last  <= rd_left == 4'd0;
                    rd_ptr  <= rd_ptr + 1'b1;
                    rd_left <= rd_left - 1'b1;
                    rd_busy <= rd_left != 4'd0;
                end
            end
            if (arvalid && arready) begin
                rd_ptr  <= ar.addr[ptr_w+1:2];
                rd_left <= ar.len;
                rd_busy <= 1'b1;
            end

            if (awvalid && awready) begin
                wr_ptr   <= aw.addr[ptr_w+1:2];
                wr_busy  <= 1'b1;
                aw_count <= aw_count + 1;
                aw_len   <= aw.len;
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (w.strb[b]) begin
                        mem[wr_ptr][8*b +: 8] <= w.data[8*b +: 8];
                    end
                end
                wr_ptr <= wr_ptr + 1'b1;
                if (w.last) begin
                    b_due <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                wr_busy <= 1'b0;
            end else if (b_due && (!stall || rnd[9:8] != 2'b00)) begin
                bvalid <= 1'b1;
                b_due  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* test/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_tb;

    import dcache_pkg::*;

    localparam int          period       = 100;
    localparam int          mem_words    = 5120;
    localparam int          reset_cycles = 8;
    localparam int          cached_ops   = 500;
    localparam int          unc_ops      = 100;
    localparam int          total_ops    = 2 + 2 * cached_ops + unc_ops;
    localparam int          limit_cycles = total_ops * 40 + reset_cycles + 40;
    localparam logic [31:0] seed_init    = 32'hb21310c9;

    logic     clk = 1'b0;
    logic     rst;
    logic     req;
    logic     stall;
    cpu_req_t cpu;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata;
    axi_ar_t  ar;
    logic     arvalid;
    logic     arready;
    axi_r_t   r;
    logic     rvalid;
    logic     rready;
    axi_aw_t  aw;
    logic     awvalid;
    logic     awready;
    axi_w_t   w;
    logic     wvalid;
    logic     wready;
    logic     bvalid;
    logic     bready;
    int       aw_count;
    logic [3:0] aw_len;

    int    seed      = seed_init;
    int    errors    = 0;
    int    checks    = 0;
    int    accepted  = 0;
    int    completed = 0;
    word_t model [mem_words];

    dcache uut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .cpu     (cpu),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    axi_mem_model #(.words(mem_words), .seed(seed_init)) u_mem (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready),
        .aw_count (aw_count),
        .aw_len   (aw_len)
    );

    always #(period / 2) clk = ~clk;

    // every accepted request must see one data_ok
    always @(negedge clk) begin
        if (!rst && req && addr_ok) begin
            accepted++;
        end
        if (!rst && data_ok) begin
            completed++;
        end
    end

    function automatic word_t fill_word(input int i);
        return 32'(i) * 32'h9e3779b9 ^ 32'h5bd1e995;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // hold req until addr_ok, then count cycles to data_ok
    task automatic access(input cpu_req_t op, output word_t rd, output int lat);
        @(posedge clk);
        req <= 1'b1;
        cpu <= op;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        req <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!data_ok);
        rd = rdata;
    endtask

    task automatic cpu_op(input logic wr, input logic [3:0] sel, input logic [2:0] seg,
                          input logic [14:0] phys, input word_t wdata, output int lat);
        cpu_req_t op;
        word_t    rd;
        int       i;
        i  = int'(phys[14:2]);
        op = '{wr: wr, sel: sel, addr: {seg, 14'd0, phys}, wdata: wdata};
        access(op, rd, lat);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    model[i][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else begin
            check_value("rdata", rd, model[i]);
        end
    endtask

    // cached traffic over 16 KB, twice the cache size
    task automatic random_cached(input int n);
        logic [31:0] rv;
        logic [31:0] wd;
        int          lat;
        for (int k = 0; k < n; k++) begin
            rv = $random(seed);
            wd = $random(seed);
            cpu_op(rv[0], rv[4:1], rv[5] ? `DCACHE_SEG_DIRECT : 3'b000,
                   {1'b0, rv[17:6], 2'b00}, wd, lat);
        end
    endtask

    initial begin
        int          base;
        int          lat;
        int          aw_before;
        logic [31:0] rv;
        logic [31:0] wd;
        rst   = 1'b1;
        req   = 1'b0;
        stall = 1'b0;
        cpu   = '0;
        for (int i = 0; i < mem_words; i++) begin
            model[i] = fill_word(i);
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        base = errors;
        repeat (20) begin
            @(negedge clk);
            check_value("addr_ok", 32'(addr_ok), 32'd0);
            check_value("data_ok", 32'(data_ok), 32'd0);
            check_value("arvalid", 32'(arvalid), 32'd0);
            check_value("awvalid", 32'(awvalid), 32'd0);
            // responses are always accepted
            check_value("rready", 32'(rready), 32'd1);
            check_value("bready", 32'(bready), 32'd1);
        end
        report("test 1 idle after reset", base);

        base = errors;
        cpu_op(1'b0, 4'hf, `DCACHE_SEG_DIRECT, 15'h0040, '0, lat);
        cpu_op(1'b0, 4'hf, `DCACHE_SEG_DIRECT, 15'h0040, '0, lat);
        check_value("hit latency", 32'(lat), 32'd1);
        report("test 2 read hit timing", base);

        base = errors;
        random_cached(cached_ops);
        report("test 3 random cached traffic", base);

        // uncached window at physical 0x4000, 64 words for reuse
        base = errors;
        for (int k = 0; k < unc_ops; k++) begin
            rv        = $random(seed);
            wd        = $random(seed);
            aw_before = aw_count;
            cpu_op(rv[0], rv[4:1], `DCACHE_SEG_UNCACHED, {3'b100, 4'd0, rv[11:6], 2'b00},
                   wd, lat);
            check_value("aw count", 32'(aw_count), 32'(aw_before + (rv[0] ? 1 : 0)));
            if (rv[0]) begin
                check_value("aw len", 32'(aw_len), 32'd0);
            end
        end
        report("test 4 uncached access", base);

        base = errors;
        @(posedge clk);
        stall <= 1'b1;
        random_cached(cached_ops);
        repeat (2) @(posedge clk);
        check_value("data_ok count", 32'(completed), 32'(accepted));
        report("test 5 memory back-pressure", base);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(limit_cycles * period);
        $display("watchdog expired after %0d cycles, a request never completed",
                 limit_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
